/* list.f */
logic/sparse_gather_pkg.sv
logic/sparse_prefix_sum.sv
logic/nonzero_scanner.sv
logic/ifm_input_sel.sv
logic/chunk_sequencer.sv
logic/ifm_gather_top.sv
verif/tb_ifm_gather.sv

/* logic/chunk_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_sequencer
	import sparse_gather_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_i,

	input  logic         cmd_req_i,
	input  chunk_cmd_t   cmd_i,
	output logic         cmd_ack_o,

	output logic         sm_rd_o,
	output sm_addr_t     sm_addr_o,
	input  sm_word_t     sm_data_i,

	output logic         load_o,
	output logic         advance_o,
	output sm_word_t     word_o,
	input  logic         empty_i,
	input  bit_idx_t     bit_i,
	input  val_addr_t    val_addr_i,

	output logic         base_clr_o,
	output logic         base_add_o,

	output logic         elem_req_o,
	output gather_elem_t elem_o,
	input  logic         elem_ack_i
);

	seq_state_t   state_r;
	seq_state_t   state_n;

	chunk_cmd_t   cmd_r;
	sm_addr_t     word_idx_r;
	sm_word_t     word_r;
	gather_elem_t elem_r;
	elem_pos_t    pos_w;

	logic         cmd_ack_r;
	logic         elem_req_r;
	logic         accept_w;
	logic         last_word_w;

	assign accept_w    = (state_r == IDLE) && cmd_req_i;
	assign last_word_w = (word_idx_r == cmd_r.last_word);

	// Position inside the chunk
	assign pos_w = elem_pos_t'(word_idx_r) * elem_pos_t'(PS_SIZE) + elem_pos_t'(bit_i);

	////////////////////
	// FSM
	////////////////////

	always_comb begin
		state_n = state_r;
		case (state_r)
			IDLE: begin
				if (cmd_req_i) begin
					state_n = FETCH;
				end
			end
			FETCH: state_n = LOAD;
			LOAD:  state_n = SCAN;
			SCAN: begin
				if (!empty_i) begin
					state_n = EMIT;
				end
				else if (last_word_w) begin
					state_n = DONE;
				end
				else begin
					state_n = FETCH;
				end
			end
			EMIT: begin
				if (elem_ack_i) begin
					state_n = EMIT_WAIT;
				end
			end
			// Four-phase return to zero
			EMIT_WAIT: begin
				if (!elem_ack_i) begin
					state_n = SCAN;
				end
			end
			DONE: begin
				if (!cmd_req_i) begin
					state_n = IDLE;
				end
			end
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r    <= IDLE;
			word_idx_r <= '0;
			cmd_ack_r  <= 1'b0;
			elem_req_r <= 1'b0;
		end
		else begin
			state_r <= state_n;
			if (accept_w) begin
				word_idx_r <= '0;
			end
			else if (state_r == SCAN && empty_i && !last_word_w) begin
				word_idx_r <= word_idx_r + sm_addr_t'(1);
			end
			// Ack rises on entry to DONE and falls when the requester lets go
			if (state_r == SCAN && empty_i && last_word_w) begin
				cmd_ack_r <= 1'b1;
			end
			else if (state_r == DONE && !cmd_req_i) begin
				cmd_ack_r <= 1'b0;
			end
			if (state_r == SCAN && !empty_i) begin
				elem_req_r <= 1'b1;
			end
			else if (state_r == EMIT && elem_ack_i) begin
				elem_req_r <= 1'b0;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk_i) begin
		if (accept_w) begin
			cmd_r <= cmd_i;
		end
		if (state_r == LOAD) begin
			word_r <= sm_data_i;
		end
		if (state_r == SCAN && !empty_i) begin
			elem_r <= '{val_addr: val_addr_i, pos: pos_w};
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign cmd_ack_o  = cmd_ack_r;
	assign sm_rd_o    = (state_r == FETCH);
	assign sm_addr_o  = cmd_r.first_addr + word_idx_r;
	assign load_o     = (state_r == LOAD);
	assign advance_o  = (state_r == SCAN) && !empty_i;
	assign word_o     = word_r;
	assign base_clr_o = accept_w;
	// Word fully consumed
	assign base_add_o = (state_r == SCAN) && empty_i;
	assign elem_req_o = elem_req_r;
	assign elem_o     = elem_r;

	a_elem_stable: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(elem_req_o && !elem_ack_i) |=> (elem_req_o && $stable(elem_o))
	);

	a_ack_only_in_done: assert property (
		@(posedge clk_i) disable iff (rst_i)
		cmd_ack_o |-> (state_r == DONE)
	);

endmodule

`default_nettype wire

/* logic/ifm_gather_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifm_gather_top
	import sparse_gather_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_i,

	input  logic         cmd_req_i,
	input  chunk_cmd_t   cmd_i,
	output logic         cmd_ack_o,

	output logic         sm_rd_o,
	output sm_addr_t     sm_addr_o,
	input  sm_word_t     sm_data_i,

	output logic         elem_req_o,
	output gather_elem_t elem_o,
	input  logic         elem_ack_i
);

	logic      load;
	logic      advance;
	logic      word_done;
	logic      base_clr;
	logic      base_add;
	sm_word_t  word;
	bit_idx_t  bit_idx;
	val_addr_t val_addr;

	chunk_sequencer u_sequencer (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cmd_req_i  (cmd_req_i),
		.cmd_i      (cmd_i),
		.cmd_ack_o  (cmd_ack_o),
		.sm_rd_o    (sm_rd_o),
		.sm_addr_o  (sm_addr_o),
		.sm_data_i  (sm_data_i),
		.load_o     (load),
		.advance_o  (advance),
		.word_o     (word),
		.empty_i    (word_done),
		.bit_i      (bit_idx),
		.val_addr_i (val_addr),
		.base_clr_o (base_clr),
		.base_add_o (base_add),
		.elem_req_o (elem_req_o),
		.elem_o     (elem_o),
		.elem_ack_i (elem_ack_i)
	);

	// Loads straight from the memory port in LOAD
	nonzero_scanner u_scanner (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.load_i    (load),
		.advance_i (advance),
		.word_i    (sm_data_i),
		.bit_o     (bit_idx),
		.empty_o   (word_done)
	);

	ifm_input_sel u_input_sel (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.base_clr_i (base_clr),
		.base_add_i (base_add),
		.word_i     (word),
		.bit_i      (bit_idx),
		.val_addr_o (val_addr)
	);

endmodule

`default_nettype wire

/* logic/ifm_input_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module ifm_input_sel
	import sparse_gather_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      base_clr_i,
	input  logic      base_add_i,
	input  sm_word_t  word_i,
	input  bit_idx_t  bit_i,
	output val_addr_t val_addr_o
);

	rank_t rank_w [PS_SIZE];
	rank_t total_w;

	// Value memory offset of the current word's first nonzero
	val_addr_t base_r;

	// One bit wider to catch a wrap
	logic [VAL_ADDR_W:0] base_sum_w;

	// Full word as loaded, so the rank counts every set bit below
	sparse_prefix_sum u_prefix_sum (
		.word_i  (word_i),
		.rank_o  (rank_w),
		.total_o (total_w)
	);

	assign base_sum_w = {1'b0, base_r} + (VAL_ADDR_W + 1)'(total_w);

	////////////////////
	// Running base
	////////////////////

	// Channel padding, every chunk starts at value address 0
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_r <= '0;
		end
		else if (base_clr_i) begin
			base_r <= '0;
		end
		else if (base_add_i) begin
			base_r <= base_sum_w[VAL_ADDR_W-1:0];
		end
	end

	assign val_addr_o = base_r + val_addr_t'(rank_w[bit_i]);

	// A chunk never holds more nonzeros than the value memory can address
	a_base_no_wrap: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(base_add_i && !base_clr_i) |-> !base_sum_w[VAL_ADDR_W]
	);

endmodule

`default_nettype wire

/* logic/nonzero_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module nonzero_scanner
	import sparse_gather_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     load_i,
	input  logic     advance_i,
	input  sm_word_t word_i,
	output bit_idx_t bit_o,
	output logic     empty_o
);

	// Bits of the current word not yet visited
	sm_word_t mask_r;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mask_r <= '0;
		end
		else if (load_i) begin
			mask_r <= word_i;
		end
		else if (advance_i) begin
			// Drops the lowest set bit
			mask_r <= mask_r & (mask_r - sm_word_t'(1));
		end
	end

	////////////////////
	// Lowest set bit
	////////////////////

	always_comb begin
		bit_o = '0;
		// Scan downward so the lowest hit wins
		for (int i = PS_SIZE - 1; i >= 0; i--) begin
			if (mask_r[i]) begin
				bit_o = bit_idx_t'(i);
			end
		end
	end

	assign empty_o = (mask_r == '0);

	// Sequencer only advances on a live bit
	a_no_advance_when_empty: assert property (
		@(posedge clk_i) disable iff (rst_i)
		advance_i |-> !empty_o
	);

endmodule

`default_nettype wire

/* logic/sparse_gather_pkg.sv */
`default_nettype none

package sparse_gather_pkg;

	////////////////////
	// Widths
	////////////////////

	// Bits per sparsemap word
	localparam int PS_SIZE    = 8;
	localparam int SM_ADDR_W  = 6;
	// 64 words of 8 bits give at most 512 nonzeros
	localparam int VAL_ADDR_W = 10;

	localparam int BIT_IDX_W  = $clog2(PS_SIZE);
	localparam int RANK_W     = $clog2(PS_SIZE) + 1;
	localparam int ELEM_POS_W = SM_ADDR_W + BIT_IDX_W;

	typedef logic [PS_SIZE-1:0]    sm_word_t;
	typedef logic [BIT_IDX_W-1:0]  bit_idx_t;
	typedef logic [RANK_W-1:0]     rank_t;
	typedef logic [SM_ADDR_W-1:0]  sm_addr_t;
	typedef logic [VAL_ADDR_W-1:0] val_addr_t;
	typedef logic [ELEM_POS_W-1:0] elem_pos_t;

	////////////////////
	// Bundles
	////////////////////

	typedef struct packed {
		sm_addr_t first_addr;
		// Word count minus one
		sm_addr_t last_word;
	} chunk_cmd_t;

	typedef struct packed {
		val_addr_t val_addr;
		elem_pos_t pos;
	} gather_elem_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		LOAD,
		SCAN,
		EMIT,
		EMIT_WAIT,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* logic/sparse_prefix_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module sparse_prefix_sum
	import sparse_gather_pkg::*;
(
	input  sm_word_t word_i,
	output rank_t    rank_o [PS_SIZE],
	output rank_t    total_o
);

	// Running count chain, one adder per bit
	rank_t chain_w [PS_SIZE+1];

	always_comb begin
		chain_w[0] = '0;
		for (int k = 0; k < PS_SIZE; k++) begin
			chain_w[k+1] = chain_w[k] + rank_t'(word_i[k]);
		end
	end

	// Exclusive count, bit k sees only the bits below it
	always_comb begin
		for (int k = 0; k < PS_SIZE; k++) begin
			rank_o[k] = chain_w[k];
		end
	end

	assign total_o = chain_w[PS_SIZE];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the gather testbench with Verilator and runs it.
# The script exits with the simulator's status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_ifm_gather \
	-f list.f \
	-o sim_ifm_gather
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_ifm_gather
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi

exit 0

/* verif/tb_ifm_gather.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifm_gather
	import sparse_gather_pkg::*;
();

	// Upper bound on words over all tests, random chunks take up to 16 words
	localparam int MAX_WORDS      = 1 + 4 + 5 + 3 + 3 + 2 * 4 + 20 * 16;
	localparam int MAX_ELEMS      = MAX_WORDS * PS_SIZE;
	localparam int TIMEOUT_CYCLES = 20 * MAX_WORDS + 12 * MAX_ELEMS + 200;

	logic         clk;
	logic         rst;
	logic         cmd_req;
	chunk_cmd_t   cmd;
	logic         cmd_ack;
	logic         sm_rd;
	sm_addr_t     sm_addr;
	sm_word_t     sm_data;
	logic         elem_req;
	gather_elem_t elem;
	logic         elem_ack;

	sm_word_t     sm_mem [64];
	gather_elem_t got_q [$];
	gather_elem_t exp_q [$];
	int           cycle_cnt = 0;

	ifm_gather_top i_dut (
		.clk_i      (clk),
		.rst_i      (rst),
		.cmd_req_i  (cmd_req),
		.cmd_i      (cmd),
		.cmd_ack_o  (cmd_ack),
		.sm_rd_o    (sm_rd),
		.sm_addr_o  (sm_addr),
		.sm_data_i  (sm_data),
		.elem_req_o (elem_req),
		.elem_o     (elem),
		.elem_ack_i (elem_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Sparsemap memory, one cycle read latency
	always @(posedge clk) begin
		if (sm_rd) begin
			sm_data <= sm_mem[sm_addr];
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run hung, no completion within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string test_name, input int expected, input int actual);
		if (expected != actual) begin
			$display("Error: %s expected %0d actual %0d", test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string test_name, input int expected, input int actual);
		if (expected != actual) begin
			$display("%s: wrong number of elements, expected %0d but the DUT gave %0d",
				test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Background fill, every word differs with the address
	task automatic init_memory();
		for (int a = 0; a < 64; a++) begin
			sm_mem[a] = sm_word_t'({a[5:0], 2'b10});
		end
	endtask

	// Issues one command and acts as element consumer until the ack returns low
	task automatic run_chunk(input string test_name, input sm_addr_t first, input int nwords,
		input int max_delay);
		int wait_cnt;
		int rd_cnt;
		int cyc;
		bit done;
		got_q.delete();
		wait_cnt = $urandom_range(max_delay, 0);
		rd_cnt = 0;
		cyc = 0;
		done = 1'b0;
		@(posedge clk);
		cmd     <= '{first_addr: first, last_word: sm_addr_t'(nwords - 1)};
		cmd_req <= 1'b1;
		while (!done) begin
			@(posedge clk);
			cyc++;
			// Sparsemap fetches walk the chunk in order
			if (sm_rd) begin
				if (rd_cnt == 0) begin
					check_value($sformatf("%s first read cycle", test_name), 2, cyc);
				end
				check_value($sformatf("%s read addr %0d", test_name, rd_cnt),
					int'(sm_addr_t'(first + rd_cnt)), int'(sm_addr));
				rd_cnt++;
			end
			if (elem_ack) begin
				if (!elem_req) begin
					elem_ack <= 1'b0;
					wait_cnt = $urandom_range(max_delay, 0);
				end
			end
			else if (elem_req) begin
				if (wait_cnt == 0) begin
					got_q.push_back(elem);
					elem_ack <= 1'b1;
				end
				else begin
					wait_cnt--;
				end
			end
			if (cmd_ack) begin
				cmd_req <= 1'b0;
				done = 1'b1;
			end
		end
		check_value($sformatf("%s read count", test_name), nwords, rd_cnt);
		// Four-phase return to zero
		while (cmd_ack) begin
			@(posedge clk);
		end
	endtask

	// Reference model, address is the running popcount over the chunk
	task automatic build_expected(input sm_addr_t first, input int nwords);
		int running;
		sm_word_t word;
		gather_elem_t e;
		exp_q.delete();
		running = 0;
		for (int w = 0; w < nwords; w++) begin
			word = sm_mem[sm_addr_t'(first + w)];
			for (int b = 0; b < PS_SIZE; b++) begin
				if (word[b]) begin
					e.val_addr = val_addr_t'(running);
					e.pos      = elem_pos_t'(w * PS_SIZE + b);
					exp_q.push_back(e);
					running++;
				end
			end
		end
	endtask

	task automatic compare_with_expected(input string test_name);
		check_count(test_name, exp_q.size(), got_q.size());
		foreach (exp_q[i]) begin
			check_value($sformatf("%s elem %0d addr", test_name, i),
				int'(exp_q[i].val_addr), int'(got_q[i].val_addr));
			check_value($sformatf("%s elem %0d pos", test_name, i),
				int'(exp_q[i].pos), int'(got_q[i].pos));
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_single_word();
		int pos_tab [4];
		pos_tab = '{1, 4, 5, 7};
		sm_mem[5] = 8'b1011_0010;
		run_chunk("test_single_word", 6'd5, 1, 0);
		check_count("test_single_word", 4, got_q.size());
		for (int i = 0; i < 4; i++) begin
			check_value("test_single_word addr", i, int'(got_q[i].val_addr));
			check_value("test_single_word pos", pos_tab[i], int'(got_q[i].pos));
		end
	endtask

	task automatic test_multi_word();
		sm_mem[10] = 8'h81;
		sm_mem[11] = 8'h3c;
		sm_mem[12] = 8'h01;
		sm_mem[13] = 8'hf0;
		run_chunk("test_multi_word", 6'd10, 4, 1);
		build_expected(6'd10, 4);
		compare_with_expected("test_multi_word");
	endtask

	task automatic test_zero_words();
		sm_mem[20] = 8'h00;
		sm_mem[21] = 8'ha5;
		sm_mem[22] = 8'h00;
		sm_mem[23] = 8'h00;
		sm_mem[24] = 8'h42;
		run_chunk("test_zero_words mixed", 6'd20, 5, 1);
		build_expected(6'd20, 5);
		compare_with_expected("test_zero_words mixed");
		// Empty chunk still has to complete the command handshake
		for (int a = 30; a < 33; a++) begin
			sm_mem[a] = 8'h00;
		end
		run_chunk("test_zero_words empty", 6'd30, 3, 0);
		check_count("test_zero_words empty", 0, got_q.size());
	endtask

	task automatic test_full_words();
		for (int a = 40; a < 43; a++) begin
			sm_mem[a] = 8'hff;
		end
		run_chunk("test_full_words", 6'd40, 3, 2);
		check_count("test_full_words", 24, got_q.size());
		for (int i = 0; i < 24; i++) begin
			check_value("test_full_words addr", i, int'(got_q[i].val_addr));
			check_value("test_full_words pos", i, int'(got_q[i].pos));
		end
	endtask

	task automatic test_back_pressure_restart();
		gather_elem_t first_q [$];
		sm_mem[50] = 8'h96;
		sm_mem[51] = 8'h0f;
		sm_mem[52] = 8'h00;
		sm_mem[53] = 8'hc3;
		run_chunk("test_back_pressure_restart", 6'd50, 4, 3);
		first_q = got_q;
		run_chunk("test_back_pressure_restart rerun", 6'd50, 4, 3);
		build_expected(6'd50, 4);
		compare_with_expected("test_back_pressure_restart");
		// Second run against the first
		check_count("test_back_pressure_restart rerun", first_q.size(), got_q.size());
		foreach (first_q[i]) begin
			check_value("test_back_pressure_restart rerun addr",
				int'(first_q[i].val_addr), int'(got_q[i].val_addr));
			check_value("test_back_pressure_restart rerun pos",
				int'(first_q[i].pos), int'(got_q[i].pos));
		end
	endtask

	task automatic test_random_chunks();
		sm_addr_t first;
		int len;
		string name;
		for (int n = 0; n < 20; n++) begin
			// ANDing two draws gives sparser words
			for (int a = 0; a < 64; a++) begin
				sm_mem[a] = sm_word_t'($urandom & $urandom);
			end
			first = sm_addr_t'($urandom_range(63, 0));
			len = int'($urandom_range(16, 1));
			name = $sformatf("test_random_chunks %0d", n);
			run_chunk(name, first, len, 3);
			build_expected(first, len);
			compare_with_expected(name);
		end
	endtask

	initial begin
		void'($urandom(32'ha3ab_ab0d));
		rst      = 1'b1;
		cmd_req  = 1'b0;
		cmd      = '0;
		sm_data  = '0;
		elem_ack = 1'b0;
		init_memory();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// Handshake outputs idle out of reset
		check_value("after_reset cmd_ack", 0, int'(cmd_ack));
		check_value("after_reset elem_req", 0, int'(elem_req));
		check_value("after_reset sm_rd", 0, int'(sm_rd));
		test_single_word();
		test_multi_word();
		test_zero_words();
		test_full_words();
		test_back_pressure_restart();
		test_random_chunks();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
